// ==== bench/id_patterns.txt ====
// kind a b exp_imm exp_rs1_data exp_rs2_data exp_csr_rdata ctrl
// kind 1 rf write, 2 csr write, 3 instr (a instr, b pc), 4 flush, 5 mem stall, 6 trap commit
00000001 00000001 00001000 00000000 00000000 00000000 00000000 00000000
00000001 00000002 CAFE0002 00000000 00000000 00000000 00000000 00000000
00000001 00000000 DEADBEEF 00000000 00000000 00000000 00000000 00000000
00000003 123451B7 00000100 12345000 00000000 00000000 00000000 21000120
00000003 FFFFF217 00000104 FFFFF000 00000000 00000000 00000000 21000110
00000003 001000EF 00000108 00000800 00000000 00000000 00000000 21001210
00000003 FFC080E7 0000010C FFFFFFFC 00001000 00000000 00000000 61002210
00000003 FE208CE3 00000110 FFFFFFF8 00001000 CAFE0002 00000000 6000300C
00000003 0080A283 00000114 00000008 00000000 00000000 00000000 29010100
00000003 00228333 00000118 00000000 00000000 CAFE0002 00000000 71000000
00000003 FE20AE23 0000011C FFFFFFFC 00001000 CAFE0002 00000000 60090100
00000003 401103B3 00000120 00000000 CAFE0002 00001000 00000000 61000008
00000003 40315413 00000124 00000403 00000000 00000000 00000000 2100010D
00000003 FFF00493 00000128 FFFFFFFF 00000000 00000000 00000000 21000100
00000003 00200533 0000012C 00000000 00000000 CAFE0002 00000000 61000000
00000002 00000340 5A5A0001 00000000 00000000 00000000 00000000 00000000
00000003 3400A5F3 00000130 00000000 00000000 00000000 5A5A0001 A7000306
00000003 34003673 00000134 00000000 00000000 00000000 5A5A0001 A500030F
00000003 34011073 00000138 00000000 00000000 00000000 00000000 A7000400
00000003 340066F3 0000013C 00000000 00000000 00000000 5A5A0001 A5000336
00000003 3402F773 00000140 00000005 00000000 00000000 5A5A0001 A700033F
00000003 00000073 00000144 00000000 00000000 00000000 00000000 20200000
00000002 00000300 00000000 00000000 00000000 00000000 00000000 00000000
00000006 00000004 00000200 00000000 00000000 00000000 00000000 00000000
00000003 00000073 00000200 00000000 00000000 00000000 00000000 00100000
00000003 00100073 00000204 00000000 00000000 00000000 00000000 00300000
00000006 00000001 00000300 00000000 00000000 00000000 00000000 20000000
00000003 0000007F 00000148 00000000 00000000 00000000 00000000 20500000
00000004 00200533 0000014C 00000000 00000000 00000000 00000000 00000000
00000003 123451B7 00000150 12345000 00000000 00000000 00000000 21000120
00000005 FFF00493 00000154 00000000 00000000 00000000 00000000 00000000

// ==== bench/id_stage_properties.sv ====
/* hazard and reset properties of the decode stage
   bound into the stage top next to the hazard controller */
`timescale 1ns/100ps
`default_nettype none

module id_stage_properties
(
    input wire                 clk_i,
    input wire                 rstn_i,
    input wire                 flush_i,
    input wire                 hold_i,
    input wire                 bubble_i,
    input wire                 if_stall_i,
    input wire rv_pkg::id_ex_t id_ex_i,
    input wire [4:0]           rs1_i,
    input wire [4:0]           rs2_i
);

    wire load_use = id_ex_i.valid && id_ex_i.wb_use_mem && id_ex_i.rd != 5'd0
                 && (id_ex_i.rd == rs1_i || id_ex_i.rd == rs2_i);

    a_stall_after_reset: assert property (@(posedge clk_i) $rose(rstn_i) |-> !if_stall_i)
        else $error("if_stall_o high right after reset");

    // held slot keeps its contents
    a_hold_keeps_id_ex: assert property (@(posedge clk_i) disable iff (!rstn_i)
        hold_i |=> $stable(id_ex_i))
        else $error("id_ex changed while held");

    a_bubble_clears_id_ex: assert property (@(posedge clk_i) disable iff (!rstn_i)
        bubble_i |=> (id_ex_i == '0))
        else $error("bubble did not clear id_ex");

    // flush outranks the load-use stall
    a_load_use_stall: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (load_use && !flush_i) |-> if_stall_i)
        else $error("load-use without fetch stall");

endmodule

`default_nettype wire

// ==== bench/id_stage_tb.sv ====
/* testbench for the RV32I decode stage
   replays the pattern file and checks id_ex, stall and privilege */
`timescale 1ns/100ps
`default_nettype none

module id_stage_tb;

    localparam int NVEC   = 31;
    localparam int NWORDS = 8;  // words per vector

    logic            clk;
    logic            rstn;
    rv_pkg::instr_u  instr;
    logic [31:0]     pc;
    logic            instr_valid;
    logic            flush;
    logic            mem_stall;
    rv_pkg::rf_wr_t  rf_wr;
    rv_pkg::csr_wr_t csr_wr;
    logic            trap_commit;
    rv_pkg::trap_e   trap_cause;
    logic [31:0]     trap_pc;
    rv_pkg::id_ex_t  id_ex;
    logic            if_stall;
    rv_pkg::priv_e   cur_priv;

    logic [31:0] pat [NVEC*NWORDS];
    int          errors;

    id_stage_top #(.NREGS(32)) i_id_stage_top (
        .clk_i         (clk),
        .rstn_i        (rstn),
        .instr_i       (instr),
        .pc_i          (pc),
        .instr_valid_i (instr_valid),
        .flush_i       (flush),
        .mem_stall_i   (mem_stall),
        .rf_wr_i       (rf_wr),
        .csr_wr_i      (csr_wr),
        .trap_commit_i (trap_commit),
        .trap_cause_i  (trap_cause),
        .trap_pc_i     (trap_pc),
        .id_ex_o       (id_ex),
        .if_stall_o    (if_stall),
        .cur_priv_o    (cur_priv)
    );

    bind id_stage_top id_stage_properties i_id_stage_properties (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .flush_i    (flush_i),
        .hold_i     (hold),
        .bubble_i   (bubble),
        .if_stall_i (if_stall_o),
        .id_ex_i    (id_ex_o),
        .rs1_i      (rs1_addr),
        .rs2_i      (rs2_addr)
    );

    always #50 clk = ~clk;

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got == exp)
        else
        begin
            errors++;
            $display("mismatch %s: expected %h got %h", name, exp, got);
        end
    endtask

    // one edge with the current inputs, back at the falling edge
    task automatic step();
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic run_instr(input int base);
        logic [31:0] ctrl;
        int          guard;
        ctrl        = pat[base+7];
        instr       = pat[base+1];
        pc          = pat[base+2];
        instr_valid = 1'b1;
        guard       = 0;
        #1;
        check("if_stall_o", 32'(if_stall), 32'(ctrl[28]));
        while (if_stall && guard < 4)  // load-use, fetch keeps the instruction
        begin
            step();
            check("id_ex_o bubble", 32'(id_ex != '0), 32'd0);
            guard++;
            #1;
        end
        step();
        check("id_ex_o.valid", 32'(id_ex.valid), 32'd1);
        check("id_ex_o.pc", id_ex.pc, pat[base+2]);
        check("id_ex_o.imm", id_ex.imm, pat[base+3]);
        check("id_ex_o.alu_op", 32'(id_ex.alu_op), 32'(ctrl[3:0]));
        check("id_ex_o.oper1_src", 32'(id_ex.oper1_src), 32'(ctrl[7:4]));
        check("id_ex_o.oper2_src", 32'(id_ex.oper2_src), 32'(ctrl[11:8]));
        check("id_ex_o.bnj_op", 32'(id_ex.bnj_op), 32'(ctrl[15:12]));
        check("id_ex_o.mem_op", 32'(id_ex.mem_op), 32'(ctrl[19:16]));
        check("id_ex_o.trap", 32'(id_ex.trap), 32'(ctrl[22:20]));
        check("id_ex_o.write_rd", 32'(id_ex.write_rd), 32'(ctrl[24]));
        check("id_ex_o.csr_we", 32'(id_ex.csr_we), 32'(ctrl[25]));
        check("id_ex_o.is_csr", 32'(id_ex.is_csr), 32'(ctrl[26]));
        check("id_ex_o.wb_use_mem", 32'(id_ex.wb_use_mem), 32'(ctrl[27]));
        check("cur_priv_o", 32'(cur_priv), ctrl[29] ? 32'h3 : 32'h0);
        if (ctrl[24])  // rd sits in instr[11:7]
            check("id_ex_o.rd", 32'(id_ex.rd), 32'(pat[base+1][11:7]));
        if (ctrl[30])
        begin
            check("id_ex_o.rs1_data", id_ex.rs1_data, pat[base+4]);
            check("id_ex_o.rs2_data", id_ex.rs2_data, pat[base+5]);
            check("id_ex_o.rs1", 32'(id_ex.rs1), 32'(pat[base+1][19:15]));
            check("id_ex_o.rs2", 32'(id_ex.rs2), 32'(pat[base+1][24:20]));
        end
        if (ctrl[31])
        begin
            check("id_ex_o.csr_rdata", id_ex.csr_rdata, pat[base+6]);
            check("id_ex_o.csr_waddr", 32'(id_ex.csr_waddr), 32'(pat[base+1][31:20]));
        end
        instr_valid = 1'b0;
    endtask

    task automatic run_vector(input int v);
        int          base;
        logic [31:0] kind;
        rv_pkg::id_ex_t snap;
        base = v * NWORDS;
        kind = pat[base];
        case (kind)
            32'd1:  // register write-back
            begin
                rf_wr = '{en: 1'b1, addr: pat[base+1][4:0], data: pat[base+2]};
                step();
                rf_wr = '0;
            end
            32'd2:  // csr write
            begin
                csr_wr = '{en: 1'b1, addr: pat[base+1][11:0], data: pat[base+2]};
                step();
                csr_wr = '0;
            end
            32'd3: run_instr(base);
            32'd4:
            begin
                instr       = pat[base+1];
                instr_valid = 1'b1;
                flush       = 1'b1;
                step();
                check("id_ex_o after flush", 32'(id_ex != '0), 32'd0);
                flush       = 1'b0;
                instr_valid = 1'b0;
            end
            32'd5:  // memory back-pressure for two cycles
            begin
                snap        = id_ex;
                instr       = pat[base+1];
                instr_valid = 1'b1;
                mem_stall   = 1'b1;
                repeat (2)
                begin
                    #1;
                    check("if_stall_o", 32'(if_stall), 32'd1);
                    step();
                    check("id_ex_o held", 32'(id_ex != snap), 32'd0);
                end
                mem_stall   = 1'b0;
                instr_valid = 1'b0;
            end
            32'd6:
            begin
                trap_commit = 1'b1;
                trap_cause  = rv_pkg::trap_e'(pat[base+1][2:0]);
                trap_pc     = pat[base+2];
                step();
                trap_commit = 1'b0;
                trap_cause  = rv_pkg::NO_TRAP;
                check("cur_priv_o", 32'(cur_priv), pat[base+7][29] ? 32'h3 : 32'h0);
            end
            default:
            begin
                errors++;
                $display("pattern %0d has an unknown kind %0d", v, kind);
            end
        endcase
    endtask

    initial
    begin
        clk         = 1'b0;
        rstn        = 1'b0;
        instr       = '0;
        pc          = '0;
        instr_valid = 1'b0;
        flush       = 1'b0;
        mem_stall   = 1'b0;
        rf_wr       = '0;
        csr_wr      = '0;
        trap_commit = 1'b0;
        trap_cause  = rv_pkg::NO_TRAP;
        trap_pc     = '0;
        errors      = 0;
        $readmemh("bench/id_patterns.txt", pat);
        repeat (16) @(negedge clk);
        rstn = 1'b1;
        check("if_stall_o after reset", 32'(if_stall), 32'd0);
        for (int v = 0; v < NVEC; v++)
            run_vector(v);
        $display("checks done, errors: %0d", errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    // watchdog
    initial
    begin
        repeat (NVEC*4 + 40 + 16) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", NVEC*4 + 40);
        $display("errors: %0d", errors);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/id_csr_file.sv ====
/* machine-mode CSR subset and current privilege
   read port, write port and trap commit */
`timescale 1ns/100ps
`default_nettype none

module id_csr_file
(
    input  wire                  clk_i,
    input  wire                  rstn_i,
    input  wire                  re_i,
    input  wire [11:0]           raddr_i,
    output logic [31:0]          rdata_o,
    input  wire rv_pkg::csr_wr_t wr_i,
    input  wire                  trap_commit_i,
    input  wire rv_pkg::trap_e   trap_cause_i,
    input  wire [31:0]           trap_pc_i,
    output rv_pkg::priv_e        priv_o
);

    localparam logic [11:0] MSTATUS  = 12'h300;
    localparam logic [11:0] MTVEC    = 12'h305;
    localparam logic [11:0] MSCRATCH = 12'h340;
    localparam logic [11:0] MEPC     = 12'h341;
    localparam logic [11:0] MCAUSE   = 12'h342;

    rv_pkg::priv_e mpp;  // only field of mstatus kept
    logic [31:0]   mtvec, mscratch, mepc, mcause;
    logic [31:0]   cause_code;
    logic          trap_entry;

    always_comb
    begin
        case (trap_cause_i)
            rv_pkg::ECALL_U:    cause_code = 32'd8;
            rv_pkg::ECALL_M:    cause_code = 32'd11;
            rv_pkg::BREAKPOINT: cause_code = 32'd3;
            default:            cause_code = 32'd2;  // illegal instruction
        endcase
    end

    assign trap_entry = trap_commit_i && trap_cause_i != rv_pkg::MRET;

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            mpp      <= rv_pkg::PRIV_U;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            priv_o   <= rv_pkg::PRIV_M;
        end
        else
        begin
            if (wr_i.en)
                case (wr_i.addr)
                    MSTATUS:  mpp <= (wr_i.data[12:11] == 2'b11) ? rv_pkg::PRIV_M
                                                                 : rv_pkg::PRIV_U;
                    MTVEC:    mtvec    <= wr_i.data;
                    MSCRATCH: mscratch <= wr_i.data;
                    MEPC:     mepc     <= wr_i.data;
                    MCAUSE:   mcause   <= wr_i.data;
                    default:  ;
                endcase
            // trap commit overrides a CSR write in the same cycle
            if (trap_entry)
            begin
                mepc   <= trap_pc_i;
                mcause <= cause_code;
                mpp    <= priv_o;
                priv_o <= rv_pkg::PRIV_M;
            end
            else if (trap_commit_i)  // mret
            begin
                priv_o <= mpp;
                mpp    <= rv_pkg::PRIV_U;
            end
        end
    end

    always_comb
    begin
        rdata_o = '0;
        if (re_i)
            case (raddr_i)
                MSTATUS:  rdata_o = {19'b0, mpp, 11'b0};
                MTVEC:    rdata_o = mtvec;
                MSCRATCH: rdata_o = mscratch;
                MEPC:     rdata_o = mepc;
                MCAUSE:   rdata_o = mcause;
                default:  rdata_o = '0;
            endcase
    end

endmodule

`default_nettype wire

// ==== rtl/id_decode.sv ====
/* instruction decoder with the ID/EX pipeline register
   splits the instruction into control fields and registers them for EX */
`timescale 1ns/100ps
`default_nettype none

module id_decode
(
    input  wire                 clk_i,
    input  wire                 rstn_i,
    input  wire rv_pkg::instr_u instr_i,
    input  wire [31:0]          pc_i,
    input  wire                 valid_i,
    input  wire rv_pkg::priv_e  priv_i,
    output logic [4:0]          rs1_addr_o,
    output logic [4:0]          rs2_addr_o,
    input  wire [31:0]          rs1_data_i,
    input  wire [31:0]          rs2_data_i,
    output logic                csr_re_o,
    output logic [11:0]         csr_raddr_o,
    input  wire [31:0]          csr_rdata_i,
    input  wire                 hold_i,    // keep id_ex contents
    input  wire                 bubble_i,  // load an empty slot
    output rv_pkg::id_ex_t      id_ex_o
);

    logic [31:0]    imm_i, imm_s, imm_b, imm_u, imm_j, imm_csr;
    logic [2:0]     func3;
    logic           csr_re;
    rv_pkg::id_ex_t nxt;

    assign func3 = instr_i.r.func3;

    // immediates, each from its own format view
    assign imm_i = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
    assign imm_s = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
    assign imm_b = {{19{instr_i.b.imm12}}, instr_i.b.imm12, instr_i.b.imm11,
                    instr_i.b.imm10_5, instr_i.b.imm4_1, 1'b0};
    assign imm_u = {instr_i.u.imm, 12'b0};
    assign imm_j = {{11{instr_i.u.imm[19]}}, instr_i.u.imm[19], instr_i.u.imm[7:0],
                    instr_i.u.imm[8], instr_i.u.imm[18:9], 1'b0};
    assign imm_csr = {27'b0, instr_i.r.rs1};  // uimm sits in the rs1 field

    always_comb
    begin
        nxt           = '0;
        nxt.pc        = pc_i;
        nxt.rs1_data  = rs1_data_i;
        nxt.rs2_data  = rs2_data_i;
        nxt.csr_rdata = csr_rdata_i;
        nxt.csr_waddr = instr_i.i.imm;
        nxt.rd        = instr_i.r.rd;
        nxt.rs1       = instr_i.r.rs1;
        nxt.rs2       = instr_i.r.rs2;
        nxt.valid     = valid_i;
        csr_re        = 1'b0;

        case (instr_i.r.opcode)
            rv_pkg::LUI:
            begin
                nxt.oper1_src = rv_pkg::OP1_ZERO;
                nxt.oper2_src = rv_pkg::OP2_IMM;
                nxt.imm       = imm_u;
                nxt.write_rd  = 1'b1;
            end
            rv_pkg::AUIPC:
            begin
                nxt.oper1_src = rv_pkg::OP1_PC;
                nxt.oper2_src = rv_pkg::OP2_IMM;
                nxt.imm       = imm_u;
                nxt.write_rd  = 1'b1;
            end
            rv_pkg::JAL, rv_pkg::JALR:
            begin
                nxt.oper1_src = rv_pkg::OP1_PC;      // link value pc + 4
                nxt.oper2_src = rv_pkg::OP2_PC_INC;
                nxt.write_rd  = 1'b1;
                if (instr_i.r.opcode == rv_pkg::JAL)
                begin
                    nxt.imm    = imm_j;
                    nxt.bnj_op = rv_pkg::BNJ_JAL;
                end
                else
                begin
                    nxt.imm    = imm_i;
                    nxt.bnj_op = rv_pkg::BNJ_JALR;
                end
            end
            rv_pkg::BRANCH:
            begin
                nxt.imm    = imm_b;
                nxt.bnj_op = rv_pkg::BNJ_BRANCH;
                case (func3)
                    3'b000:  nxt.alu_op = rv_pkg::ALU_SEQ;
                    3'b001:  nxt.alu_op = rv_pkg::ALU_SNEQ;
                    3'b100:  nxt.alu_op = rv_pkg::ALU_SLT;
                    3'b101:  nxt.alu_op = rv_pkg::ALU_SGE;
                    3'b110:  nxt.alu_op = rv_pkg::ALU_SLTU;
                    3'b111:  nxt.alu_op = rv_pkg::ALU_SGEU;
                    default: nxt.trap   = rv_pkg::ILLEGAL;
                endcase
            end
            rv_pkg::LOAD:
            begin
                nxt.oper2_src  = rv_pkg::OP2_IMM;
                nxt.imm        = imm_i;
                nxt.write_rd   = 1'b1;
                nxt.wb_use_mem = 1'b1;
                nxt.mem_op     = rv_pkg::mem_op_e'({1'b0, func3 ^ 3'b011});
            end
            rv_pkg::STORE:
            begin
                nxt.oper2_src = rv_pkg::OP2_IMM;
                nxt.imm       = imm_s;
                nxt.mem_op    = rv_pkg::mem_op_e'({1'b1, func3 ^ 3'b011});
            end
            rv_pkg::ARITH:
            begin
                nxt.write_rd = 1'b1;
                nxt.alu_op   = rv_pkg::alu_op_e'({instr_i.r.func7[5], func3});
            end
            rv_pkg::ARITH_IMM:
            begin
                nxt.oper2_src = rv_pkg::OP2_IMM;
                nxt.imm       = imm_i;
                nxt.write_rd  = 1'b1;
                if (func3 == 3'b101)  // srli / srai
                    nxt.alu_op = rv_pkg::alu_op_e'({instr_i.r.func7[5], func3});
                else
                    nxt.alu_op = rv_pkg::alu_op_e'({1'b0, func3});
            end
            rv_pkg::FENCE:
            begin
                nxt.write_rd = 1'b0;  // no-op in an in-order core
            end
            rv_pkg::SYSTEM:
            begin
                if (func3 == 3'b000)
                begin
                    if (instr_i.r.func7 == 7'b0011000)
                        nxt.trap = rv_pkg::MRET;
                    else if (instr_i.i.imm == 12'd1)
                        nxt.trap = rv_pkg::BREAKPOINT;
                    else if (priv_i == rv_pkg::PRIV_M)
                        nxt.trap = rv_pkg::ECALL_M;
                    else
                        nxt.trap = rv_pkg::ECALL_U;
                end
                else if (func3 == 3'b100)
                    nxt.trap = rv_pkg::ILLEGAL;
                else
                begin
                    nxt.is_csr   = 1'b1;
                    nxt.write_rd = 1'b1;
                    // csrrw(i) with rd zero skips the read
                    csr_re = !(func3[1:0] == 2'b01 && instr_i.r.rd == 5'd0);
                    // set/clear with rs1 or uimm zero skip the write, same field
                    nxt.csr_we = (func3[1:0] == 2'b01) || (instr_i.r.rs1 != 5'd0);
                    if (func3[2])
                    begin
                        nxt.oper1_src = rv_pkg::OP1_CSR_IMM;
                        nxt.imm       = imm_csr;
                    end
                    case (func3[1:0])
                        2'b01:
                        begin
                            nxt.oper2_src = rv_pkg::OP2_ZERO;
                            nxt.alu_op    = rv_pkg::ALU_ADD;
                        end
                        2'b10:
                        begin
                            nxt.oper2_src = rv_pkg::OP2_CSR;
                            nxt.alu_op    = rv_pkg::ALU_OR;
                        end
                        default:
                        begin
                            nxt.oper2_src = rv_pkg::OP2_CSR;
                            nxt.alu_op    = rv_pkg::ALU_CLR;
                        end
                    endcase
                end
            end
            default: nxt.trap = rv_pkg::ILLEGAL;
        endcase
    end

    assign rs1_addr_o  = instr_i.r.rs1;
    assign rs2_addr_o  = instr_i.r.rs2;
    assign csr_raddr_o = instr_i.i.imm;
    assign csr_re_o    = csr_re && valid_i;  // no read side effects from empty slots

    // ID/EX register, bubble wins over hold
    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            id_ex_o <= '0;
        else if (bubble_i)
            id_ex_o <= '0;
        else if (!hold_i)
            id_ex_o <= nxt;
    end

endmodule

`default_nettype wire

// ==== rtl/id_hazard_ctrl.sv ====
/* ID stage hazard control
   flush, memory back-pressure and load-use into hold, bubble and fetch stall */
`timescale 1ns/100ps
`default_nettype none

module id_hazard_ctrl
(
    input  wire rv_pkg::id_ex_t id_ex_i,
    input  wire [4:0]           rs1_i,
    input  wire [4:0]           rs2_i,
    input  wire                 valid_i,
    input  wire                 flush_i,
    input  wire                 mem_stall_i,
    output logic                hold_o,
    output logic                bubble_o,
    output logic                if_stall_o
);

    logic load_use;

    // load in EX whose result the incoming instruction needs
    assign load_use = id_ex_i.valid && id_ex_i.wb_use_mem && id_ex_i.rd != 5'd0
                   && (id_ex_i.rd == rs1_i || id_ex_i.rd == rs2_i);

    always_comb
    begin
        hold_o     = 1'b0;
        bubble_o   = 1'b0;
        if_stall_o = 1'b0;
        if (flush_i)
            bubble_o = 1'b1;
        else if (mem_stall_i)
        begin
            hold_o     = 1'b1;
            if_stall_o = 1'b1;
        end
        else if (load_use)
        begin
            bubble_o   = 1'b1;  // fetch keeps the instruction one more cycle
            if_stall_o = 1'b1;
        end
        else if (!valid_i)
            bubble_o = 1'b1;
    end

endmodule

`default_nettype wire

// ==== rtl/id_regfile.sv ====
/* integer register file, two async read ports and one write port
   x0 reads as zero */
`timescale 1ns/100ps
`default_nettype none

module id_regfile
#(
    parameter int NREGS = 32  // 16 gives rv32e
)
(
    input  wire                 clk_i,
    input  wire                 rstn_i,
    input  wire [4:0]           raddr1_i,
    input  wire [4:0]           raddr2_i,
    output logic [31:0]         rdata1_o,
    output logic [31:0]         rdata2_o,
    input  wire rv_pkg::rf_wr_t wr_i
);

    localparam int AW = $clog2(NREGS);

    logic [31:0] regs [NREGS];

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            for (int n = 0; n < NREGS; n++)
                regs[n] <= '0;
        end
        else if (wr_i.en && wr_i.addr != 5'd0 && int'(wr_i.addr) < NREGS)
            regs[wr_i.addr[AW-1:0]] <= wr_i.data;
    end

    // old value on a same-cycle write, no bypass
    assign rdata1_o = (raddr1_i == 5'd0 || int'(raddr1_i) >= NREGS) ? 32'd0
                    : regs[raddr1_i[AW-1:0]];
    assign rdata2_o = (raddr2_i == 5'd0 || int'(raddr2_i) >= NREGS) ? 32'd0
                    : regs[raddr2_i[AW-1:0]];

endmodule

`default_nettype wire

// ==== rtl/id_stage_top.sv ====
/* RV32I instruction decode stage
   decoder, register file, CSR file and hazard control */
`timescale 1ns/100ps
`default_nettype none

module id_stage_top
#(
    parameter int NREGS = 32
)
(
    input  wire                  clk_i,
    input  wire                  rstn_i,
    input  wire rv_pkg::instr_u  instr_i,
    input  wire [31:0]           pc_i,
    input  wire                  instr_valid_i,
    input  wire                  flush_i,
    input  wire                  mem_stall_i,
    input  wire rv_pkg::rf_wr_t  rf_wr_i,
    input  wire rv_pkg::csr_wr_t csr_wr_i,
    input  wire                  trap_commit_i,
    input  wire rv_pkg::trap_e   trap_cause_i,
    input  wire [31:0]           trap_pc_i,
    output rv_pkg::id_ex_t       id_ex_o,
    output logic                 if_stall_o,
    output rv_pkg::priv_e        cur_priv_o
);

    logic [4:0]  rs1_addr, rs2_addr;
    logic [31:0] rs1_data, rs2_data;
    logic        csr_re;
    logic [11:0] csr_raddr;
    logic [31:0] csr_rdata;
    logic        hold, bubble;

    id_decode i_id_decode (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .instr_i     (instr_i),
        .pc_i        (pc_i),
        .valid_i     (instr_valid_i),
        .priv_i      (cur_priv_o),
        .rs1_addr_o  (rs1_addr),
        .rs2_addr_o  (rs2_addr),
        .rs1_data_i  (rs1_data),
        .rs2_data_i  (rs2_data),
        .csr_re_o    (csr_re),
        .csr_raddr_o (csr_raddr),
        .csr_rdata_i (csr_rdata),
        .hold_i      (hold),
        .bubble_i    (bubble),
        .id_ex_o     (id_ex_o)
    );

    id_regfile #(.NREGS(NREGS)) i_id_regfile (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .raddr1_i (rs1_addr),
        .raddr2_i (rs2_addr),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data),
        .wr_i     (rf_wr_i)
    );

    id_csr_file i_id_csr_file (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .re_i          (csr_re),
        .raddr_i       (csr_raddr),
        .rdata_o       (csr_rdata),
        .wr_i          (csr_wr_i),
        .trap_commit_i (trap_commit_i),
        .trap_cause_i  (trap_cause_i),
        .trap_pc_i     (trap_pc_i),
        .priv_o        (cur_priv_o)
    );

    id_hazard_ctrl i_id_hazard_ctrl (
        .id_ex_i     (id_ex_o),
        .rs1_i       (rs1_addr),
        .rs2_i       (rs2_addr),
        .valid_i     (instr_valid_i),
        .flush_i     (flush_i),
        .mem_stall_i (mem_stall_i),
        .hold_o      (hold),
        .bubble_o    (bubble),
        .if_stall_o  (if_stall_o)
    );

endmodule

`default_nettype wire

// ==== rtl/rv_pkg.sv ====
/* rv32i decode stage types
   opcodes, control enums, instruction formats and the ID/EX record */
`default_nettype none

package rv_pkg;

    typedef enum logic [6:0] {
        LUI       = 7'b0110111,
        AUIPC     = 7'b0010111,
        JAL       = 7'b1101111,
        JALR      = 7'b1100111,
        BRANCH    = 7'b1100011,
        LOAD      = 7'b0000011,
        STORE     = 7'b0100011,
        ARITH_IMM = 7'b0010011,
        ARITH     = 7'b0110011,
        FENCE     = 7'b0001111,
        SYSTEM    = 7'b1110011
    } opcode_e;

    // 0..7 follow func3
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,  ALU_SLL  = 4'd1,  ALU_SLT  = 4'd2,  ALU_SLTU = 4'd3,
        ALU_XOR  = 4'd4,  ALU_SRL  = 4'd5,  ALU_OR   = 4'd6,  ALU_AND  = 4'd7,
        ALU_SUB  = 4'd8,  ALU_SGE  = 4'd10, ALU_SGEU = 4'd11, ALU_SEQ  = 4'd12,
        ALU_SRA  = 4'd13, ALU_SNEQ = 4'd14,
        ALU_CLR  = 4'd15  // op2 & ~op1
    } alu_op_e;

    typedef enum logic [1:0] {OP1_RS1, OP1_PC, OP1_ZERO, OP1_CSR_IMM} oper1_src_e;
    typedef enum logic [2:0] {OP2_RS2, OP2_IMM, OP2_PC_INC, OP2_CSR, OP2_ZERO} oper2_src_e;
    typedef enum logic [1:0] {BNJ_NO, BNJ_JAL, BNJ_JALR, BNJ_BRANCH} bnj_op_e;

    // bit 3 is the store flag, low bits are func3 ^ 3'b011
    // so the unused func3 011 slot lands on zero
    typedef enum logic [3:0] {
        MEM_NOP = 4'b0000,
        MEM_LB  = 4'b0011, MEM_LH  = 4'b0010, MEM_LW = 4'b0001,
        MEM_LBU = 4'b0111, MEM_LHU = 4'b0110,
        MEM_SB  = 4'b1011, MEM_SH  = 4'b1010, MEM_SW = 4'b1001
    } mem_op_e;

    typedef enum logic [2:0] {NO_TRAP, ECALL_U, ECALL_M, BREAKPOINT, MRET, ILLEGAL} trap_e;
    typedef enum logic [1:0] {PRIV_U = 2'b00, PRIV_M = 2'b11} priv_e;

    typedef struct packed {
        logic [6:0] func7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] func3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  func3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] func3;
        logic [4:0] imm_lo;
        opcode_e    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] func3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;  // J immediate is a scramble of the same bits
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
    } instr_u;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
        logic [31:0] imm;
        logic [31:0] csr_rdata;
        oper1_src_e  oper1_src;
        oper2_src_e  oper2_src;
        alu_op_e     alu_op;
        bnj_op_e     bnj_op;
        logic        is_csr;
        logic        valid;
        mem_op_e     mem_op;
        logic [11:0] csr_waddr;
        logic        csr_we;
        logic        wb_use_mem;
        logic        write_rd;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        trap_e       trap;
    } id_ex_t;

    typedef struct packed {
        logic        en;
        logic [11:0] addr;
        logic [31:0] data;
    } csr_wr_t;

    typedef struct packed {
        logic        en;
        logic [4:0]  addr;
        logic [31:0] data;
    } rf_wr_t;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module id_stage_tb \
    -Mdir obj_dir -o id_stage_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/id_stage_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Finished with no errors$" sim.log; then
    exit 0
fi
exit 1

// ==== tb.f ====
rtl/rv_pkg.sv
rtl/id_decode.sv
rtl/id_regfile.sv
rtl/id_csr_file.sv
rtl/id_hazard_ctrl.sv
rtl/id_stage_top.sv
bench/id_stage_properties.sv
bench/id_stage_tb.sv
